// File: sim.f
src/board_pkg.sv
src/i2s_mic_receiver.sv
src/i2s_audio_out.sv
src/tm1638_controller.sv
src/audio_lab_core.sv
src/board_top.sv
test/board_top_checker.sv
test/tb_board_top.sv

// File: Bender.yml
package:
  name: board_audio

sources:
  - src/board_pkg.sv
  - src/i2s_mic_receiver.sv
  - src/i2s_audio_out.sv
  - src/tm1638_controller.sv
  - src/audio_lab_core.sv
  - src/board_top.sv
  - target: test
    files:
      - test/board_top_checker.sv
      - test/tb_board_top.sv

// File: test/tb_board_top.sv
/*
 * Testbench for the board top with microphone, panel and DAC models
 * and a reference model of the gain, buffer and panel contents
 */

module tb_board_top
    import board_pkg::*;
;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int i2s_clk_div   = 8;
    localparam int tm_clk_div    = 4;
    localparam int frames_needed = 40;
    localparam int loops_needed  = 8;
    localparam int wait_limit    = 4000;

    // Field b differs from a only around a gain change
    typedef struct packed {
        audio_sample_t a;
        audio_sample_t b;
    } exp_t;

    logic clk;
    logic rst_n;
    logic mic_sd;
    logic mic_sck;
    logic mic_ws;
    logic dac_mclk;
    logic dac_bclk;
    logic dac_lrclk;
    logic dac_sdata;
    logic tm_clk;
    logic tm_stb;
    wire  tm_dio;
    logic panel_oe;
    logic panel_bit;

    exp_t          exp_q[$];
    exp_t          hist[$];
    int            pushes;
    int            gain;
    int            prev_gain;
    realtime       t_gain;
    realtime       t_push;
    mic_sample_t   word;
    int            slot;
    logic          prev_sck;
    logic          prev_stb;
    logic          prev_tclk;
    int            burst;
    int            rises;
    int            rd_rises;
    int            rd_bits;
    int            rel_cnt;
    logic [7:0]    cur;
    logic [7:0]    bytes[$];
    tm_keys_t      drv_keys;
    int            snap_gain;
    int            loops;
    logic          prev_bclk;
    logic          lr_prev;
    int            pos;
    logic [15:0]   acc;
    audio_sample_t left;
    audio_sample_t last_dac;
    int            frames;
    logic          prev_mclk;

    assign tm_dio = panel_oe ? panel_bit : 1'bz;

    board_top #(
        .i2s_clk_div (i2s_clk_div),
        .tm_clk_div  (tm_clk_div)
    )
    i_board_top
    (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .mic_sd    ( mic_sd    ),
        .mic_sck   ( mic_sck   ),
        .mic_ws    ( mic_ws    ),
        .dac_mclk  ( dac_mclk  ),
        .dac_bclk  ( dac_bclk  ),
        .dac_lrclk ( dac_lrclk ),
        .dac_sdata ( dac_sdata ),
        .tm_clk    ( tm_clk    ),
        .tm_stb    ( tm_stb    ),
        .tm_dio    ( tm_dio    )
    );

    bind board_top board_top_checker i_checker
    (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .tm_stb    ( tm_stb    ),
        .tm_clk    ( tm_clk    ),
        .dac_bclk  ( dac_bclk  ),
        .dac_lrclk ( dac_lrclk )
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ------------------------------
    // Reference model
    function automatic audio_sample_t scale_ref(input mic_sample_t w, input int g);
        int t;
        t = $signed(w[23:8]);
        t = t * (1 << g);
        if (t > 32767)
            t = 32767;
        if (t < -32768)
            t = -32768;
        return audio_sample_t'(t);
    endfunction

    function automatic int highest_key(input tm_keys_t k);
        int g;
        g = 0;
        for (int i = 0; i < 8; i++)
            if (k[i])
                g = i;
        return g;
    endfunction

    function automatic panel_t make_panel(input audio_sample_t s, input bit valid,
                                          input int g);
        panel_t p;
        int     mag;
        p   = '0;
        mag = (s < 0) ? -int'(s) : int'(s);
        for (int i = 0; i < 4; i++)
            p.digit[i] = valid ? seg_hex(s[4 * i +: 4]) : 8'h00;
        p.digit[7] = seg_hex(4'(g));
        for (int n = 0; n < 8; n++)
            p.led[n] = valid && (mag >= (1 << (8 + n)));
        return p;
    endfunction

    // Returns act when a recent sample explains it and the newest sample's panel otherwise
    function automatic panel_t best_panel(input panel_t act, input int g);
        panel_t p;
        p = make_panel('0, 1'b0, g);
        if (pushes < 4 && act == p)
            return p;
        foreach (hist[i])
        begin
            if (act == make_panel(hist[i].a, 1'b1, g))
                return act;
            if (act == make_panel(hist[i].b, 1'b1, g))
                return act;
        end
        if (hist.size() > 0)
            p = make_panel(hist[hist.size() - 1].a, 1'b1, g);
        return p;
    endfunction

    // ------------------------------
    // Failure and compare tasks
    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_sample(input string name, input audio_sample_t exp,
                                input audio_sample_t act);
        if (act !== exp)
            stop_run($sformatf("** Error %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_panel(input string name, input panel_t exp, input panel_t act);
        if (act !== exp)
            stop_run($sformatf("** Error %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_keys(input string name, input tm_keys_t exp, input tm_keys_t act);
        if (act !== exp)
            stop_run($sformatf("** Error %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic push_sample();
        exp_t e;
        e.a = scale_ref(word, gain);
        e.b = ($realtime - t_gain < 300.0) ? scale_ref(word, prev_gain) : e.a;
        exp_q.push_back(e);
        hist.push_back(e);
        if (hist.size() > 6)
            void'(hist.pop_front());
        pushes++;
        t_push = $realtime;
    endtask

    task automatic update_gain(input int g);
        exp_t e;
        if (g != gain)
        begin
            prev_gain = gain;
            gain      = g;
            t_gain    = $realtime;
            // Last sample may have met the new gain inside the DUT
            if ($realtime - t_push < 300.0 && exp_q.size() > 0)
            begin
                e   = exp_q[exp_q.size() - 1];
                e.b = scale_ref(word, g);
                exp_q[exp_q.size() - 1] = e;
                hist[hist.size() - 1]   = e;
            end
        end
    endtask

    // ------------------------------
    // Microphone model drives a new bit after each sck fall
    task automatic drive_mic();
        if (prev_sck && !mic_sck)
        begin
            slot = (slot + 1) % 64;
            if (mic_ws !== slot[5])
                stop_run("Microphone word select out of step with the bit clock");
            if (slot == 1)
            begin
                word = mic_sample_t'($urandom);
                word = word >>> ($urandom % 12);
            end
            if (slot >= 1 && slot <= 24)
                mic_sd = word[24 - slot];
            else
                mic_sd = 1'($urandom);
        end
        if (!prev_sck && mic_sck && slot == 24)
            push_sample();
        prev_sck = mic_sck;
    endtask

    // ------------------------------
    // TM1638 panel model
    task automatic end_burst();
        panel_t act;
        logic [7:0] cmd[4];
        int         len[4];
        cmd = '{tm_cmd_write_auto, tm_cmd_addr0, tm_cmd_display_on, tm_cmd_read_keys};
        len = '{1, 17, 1, 1};
        if (bytes.size() != len[burst] || bytes[0] !== cmd[burst] || rises % 8 != 0)
            stop_run($sformatf("Panel burst %0d has a wrong command or length", burst));
        if (burst == 1)
        begin
            for (int n = 0; n < 8; n++)
            begin
                act.digit[n] = bytes[1 + 2 * n];
                act.led[n]   = bytes[2 + 2 * n][0];
                if (bytes[2 + 2 * n][7:1] != 7'd0)
                    stop_run("Panel LED byte has bits set above bit 0");
            end
            if (loops == 0)
                check_panel("reset_panel", make_panel('0, 1'b0, 0), act);
            else
                check_panel("panel_contents", best_panel(act, snap_gain), act);
        end
        if (burst == 3)
        begin
            if (rd_rises != 32)
                stop_run("Panel key read does not have four bytes");
            update_gain(highest_key(drv_keys));
            check_keys("keys", drv_keys, i_board_top.keys);
            loops++;
        end
        burst = (burst + 1) % 4;
    endtask

    task automatic model_panel();
        int k;
        int b;
        if (rel_cnt > 0)
        begin
            rel_cnt--;
            if (rel_cnt == 0)
                panel_oe = 1'b0;
        end
        if (prev_stb && !tm_stb)
        begin
            rises    = 0;
            rd_rises = 0;
            rd_bits  = 0;
            bytes.delete();
            if (burst == 0)
                snap_gain = gain;
            if (burst == 3)
                drv_keys = tm_keys_t'($urandom);
        end
        if (!tm_stb && !prev_tclk && tm_clk)
        begin
            if (burst == 3 && bytes.size() > 0)
            begin
                rd_rises++;
                // Let go after the controller samples the last bit
                if (rd_rises == 32)
                    rel_cnt = tm_clk_div / 2 + 1;
            end
            else
            begin
                cur = {tm_dio, cur[7:1]};
                rises++;
                if (rises % 8 == 0)
                    bytes.push_back(cur);
            end
        end
        if (!tm_stb && prev_tclk && !tm_clk && burst == 3 && bytes.size() > 0 && rd_bits < 32)
        begin
            k = rd_bits / 8;
            b = rd_bits % 8;
            panel_oe  = 1'b1;
            panel_bit = (b == 0) ? drv_keys[2 * k] : ((b == 4) ? drv_keys[2 * k + 1]
                                                               : 1'($urandom));
            rd_bits++;
        end
        if (!prev_stb && tm_stb)
            end_burst();
        prev_stb  = tm_stb;
        prev_tclk = tm_clk;
    endtask

    // ------------------------------
    // DAC monitor
    // The word sits in slots 1 to 15 and in slot 0 of the next half
    task automatic frame_done(input audio_sample_t r);
        check_sample("dac_left_right", left, r);
        if (r !== last_dac)
        begin
            while (exp_q.size() > 0 && exp_q[0].a !== r && exp_q[0].b !== r)
                void'(exp_q.pop_front());
            if (exp_q.size() == 0)
                check_sample("dac_sequence", last_dac, r);
            void'(exp_q.pop_front());
            last_dac = r;
        end
        frames++;
    endtask

    task automatic capture_dac();
        if (!prev_bclk && dac_bclk)
        begin
            if (pos < 0)
                pos = 0;
            else if (dac_lrclk !== lr_prev)
            begin
                if (pos != 15)
                    stop_run("DAC half frame is not 16 bit clocks long");
                if (!lr_prev)
                    left = {acc[14:0], dac_sdata};
                else
                    frame_done({acc[14:0], dac_sdata});
                pos = 0;
            end
            else
            begin
                pos++;
                acc = {acc[14:0], dac_sdata};
            end
            lr_prev = dac_lrclk;
        end
        prev_bclk = dac_bclk;
    endtask

    // Master clock runs at half the system clock
    task automatic verify_mclk();
        if (dac_mclk === prev_mclk || $isunknown(dac_mclk))
            stop_run("dac_mclk does not toggle on every clk cycle");
        prev_mclk = dac_mclk;
    endtask

    // ------------------------------
    initial
    begin
        int idle;
        int loop_idle;
        int last_frames;
        int last_loops;
        void'($urandom(32'h97a8));
        rst_n     = 1'b0;
        mic_sd    = 1'b0;
        panel_oe  = 1'b0;
        panel_bit = 1'b1;
        pushes    = 0;
        gain      = 0;
        prev_gain = 0;
        t_gain    = -1000.0;
        t_push    = -1000.0;
        word      = '0;
        slot      = 0;
        prev_sck  = 1'b0;
        prev_stb  = 1'b1;
        prev_tclk = 1'b1;
        burst     = 0;
        rel_cnt   = 0;
        drv_keys  = '0;
        snap_gain = 0;
        loops     = 0;
        prev_bclk = 1'b0;
        lr_prev   = 1'b0;
        pos       = -1;
        acc       = '0;
        left      = '0;
        last_dac  = '0;
        frames    = 0;
        prev_mclk = 1'b0;
        repeat (16) @(posedge clk);
        #2;
        rst_n = 1'b1;
        if (tm_stb !== 1'b1 || tm_clk !== 1'b1 || tm_dio !== 1'b1 || mic_sck !== 1'b0
            || mic_ws !== 1'b0 || dac_bclk !== 1'b0 || dac_lrclk !== 1'b0
            || dac_sdata !== 1'b0)
            stop_run("Pins are not at their reset values after reset release");
        prev_mclk   = dac_mclk;
        idle        = 0;
        loop_idle   = 0;
        last_frames = 0;
        last_loops  = 0;
        while (frames < frames_needed || loops < loops_needed)
        begin
            @(posedge clk);
            #2;
            drive_mic();
            model_panel();
            capture_dac();
            verify_mclk();
            if (i_board_top.i_checker.fail_count != 0)
                stop_run("A bound protocol assertion failed");
            idle      = (frames != last_frames) ? 0 : idle + 1;
            loop_idle = (loops != last_loops) ? 0 : loop_idle + 1;
            last_frames = frames;
            last_loops  = loops;
            if (idle > wait_limit)
                stop_run("Timeout while waiting for a DAC frame");
            if (loop_idle > wait_limit)
                stop_run("Timeout while waiting for a panel refresh loop");
        end
        if (i_board_top.i_checker.fail_count == 0)
        begin
            $display("Everything OK");
            $finish;
        end
        else
            stop_run("A bound protocol assertion failed");
    end

endmodule

// File: test/board_top_checker.sv
/*
 * Bound protocol checker for the board top pins
 */

module board_top_checker
(
    input logic clk,
    input logic rst_n,
    input logic tm_stb,
    input logic tm_clk,
    input logic dac_bclk,
    input logic dac_lrclk
);

    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;

    // Panel lines idle high straight out of reset
    a_panel_idle_after_reset: assert property (
        @(posedge clk) $rose(rst_n) |-> (tm_stb && tm_clk))
    else
    begin
        fail_count++;
        $error("tm_stb or tm_clk low in the first cycle after reset");
    end

    // Word select moves together with a falling bit clock
    a_lrclk_on_bclk_fall: assert property (
        @(posedge clk) disable iff (!rst_n) $changed(dac_lrclk) |-> $fell(dac_bclk))
    else
    begin
        fail_count++;
        $error("dac_lrclk changed away from a falling dac_bclk");
    end

    a_tm_clk_high_outside_burst: assert property (
        @(posedge clk) disable iff (!rst_n) tm_stb |-> tm_clk)
    else
    begin
        fail_count++;
        $error("tm_clk low while tm_stb is high");
    end

endmodule

// File: src/board_top.sv
/*
 * Board top, ties the microphone, audio core, DAC and TM1638 panel
 * to the physical pins
 */

module board_top
    import board_pkg::*;
#(
    parameter int i2s_clk_div = 8,
    parameter int tm_clk_div  = 4
)
(
    input  logic clk,
    input  logic rst_n,
    input  logic mic_sd,
    output logic mic_sck,
    output logic mic_ws,
    output logic dac_mclk,
    output logic dac_bclk,
    output logic dac_lrclk,
    output logic dac_sdata,
    output logic tm_clk,
    output logic tm_stb,
    inout  wire  tm_dio
);

    mic_sample_t   mic_sample;
    logic          mic_valid;
    logic          out_valid;
    logic          out_ready;
    audio_sample_t out_sample;
    panel_t        panel;
    tm_keys_t      keys;

    // ------------------------------

    i2s_mic_receiver # (.i2s_clk_div (i2s_clk_div))
    i_microphone
    (
        .clk          ( clk        ),
        .rst_n        ( rst_n      ),
        .sd           ( mic_sd     ),
        .sck          ( mic_sck    ),
        .ws           ( mic_ws     ),
        .sample       ( mic_sample ),
        .sample_valid ( mic_valid  )
    );

    audio_lab_core i_lab_core
    (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .mic_sample ( mic_sample ),
        .mic_valid  ( mic_valid  ),
        .out_ready  ( out_ready  ),
        .keys       ( keys       ),
        .out_valid  ( out_valid  ),
        .out_sample ( out_sample ),
        .panel      ( panel      )
    );

    // ------------------------------

    i2s_audio_out # (.i2s_clk_div (i2s_clk_div))
    i_audio
    (
        .clk       ( clk        ),
        .rst_n     ( rst_n      ),
        .in_valid  ( out_valid  ),
        .in_sample ( out_sample ),
        .in_ready  ( out_ready  ),
        .mclk      ( dac_mclk   ),
        .bclk      ( dac_bclk   ),
        .lrclk     ( dac_lrclk  ),
        .sdata     ( dac_sdata  )
    );

    tm1638_controller # (.tm_clk_div (tm_clk_div))
    i_tm1638
    (
        .clk      ( clk    ),
        .rst_n    ( rst_n  ),
        .panel    ( panel  ),
        .keys     ( keys   ),
        .sio_clk  ( tm_clk ),
        .sio_stb  ( tm_stb ),
        .sio_data ( tm_dio )
    );

endmodule

// File: src/audio_lab_core.sv
/*
 * Audio lab core, scales microphone samples by the key-selected gain
 * and builds the level meter and hex display for the panel
 */

module audio_lab_core
    import board_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  mic_sample_t   mic_sample,
    input  logic          mic_valid,
    input  logic          out_ready,
    input  tm_keys_t      keys,
    output logic          out_valid,
    output audio_sample_t out_sample,
    output panel_t        panel
);

    gain_t              gain;
    gain_t              gain_next;
    audio_sample_t      top_word;
    logic signed [22:0] scaled;
    audio_sample_t      saturated;
    audio_sample_t      shown;
    logic               shown_valid;
    logic [16:0]        magnitude;

    // Highest pressed key wins
    always_comb
    begin
        gain_next = '0;
        for (int i = 0; i < 8; i++)
            if (keys[i])
                gain_next = 3'(i);
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            gain <= '0;
        else
            gain <= gain_next;
    end

    // ------------------------------
    // Gain and saturation
    assign top_word = mic_sample[23:8];
    assign scaled   = {{7{top_word[15]}}, top_word} <<< gain;

    always_comb
    begin
        if (scaled > 23'sd32767)
            saturated = 16'sh7fff;
        else if (scaled < -23'sd32768)
            saturated = 16'sh8000;
        else
            saturated = scaled[15:0];
    end

    // One-entry buffer, a fresh sample replaces one still waiting
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            out_valid <= 1'b0;
        else if (mic_valid)
            out_valid <= 1'b1;
        else if (out_ready)
            out_valid <= 1'b0;
        if (mic_valid)
            out_sample <= saturated;
    end

    // Sample taken by the transmitter drives the display
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            shown_valid <= 1'b0;
        else if (out_valid && out_ready)
            shown_valid <= 1'b1;
        if (out_valid && out_ready)
            shown <= out_sample;
    end

    // ------------------------------
    // Panel contents
    assign magnitude = shown[15] ? (17'd0 - {1'b1, shown}) : {1'b0, shown};

    always_comb
    begin
        panel = '0;
        for (int i = 0; i < 4; i++)
            panel.digit[i] = shown_valid ? seg_hex(shown[4 * i +: 4]) : 8'h00;
        panel.digit[7] = seg_hex({1'b0, gain});
        // Thermometer meter, LED n at 2 ** (8 + n)
        for (int n = 0; n < 8; n++)
            panel.led[n] = shown_valid && (magnitude >= (17'd1 << (8 + n)));
    end

endmodule

// File: src/tm1638_controller.sv
/*
 * TM1638 panel driver, refreshes digits and LEDs and scans the keys
 * in an endless loop of command, data and read bursts
 */

module tm1638_controller
    import board_pkg::*;
#(
    parameter int tm_clk_div = 4
)
(
    input  logic     clk,
    input  logic     rst_n,
    input  panel_t   panel,
    output tm_keys_t keys,
    output logic     sio_clk,
    output logic     sio_stb,
    inout  wire      sio_data
);

    localparam int half_div = tm_clk_div / 2;
    localparam int w_div    = $clog2(tm_clk_div);

    typedef enum logic [2:0] {ST_GAP, ST_START, ST_LOW, ST_HIGH, ST_STOP} state_t;

    state_t             state;
    logic [w_div - 1:0] div_cnt;
    logic               tick;
    logic [1:0]         burst;
    logic [4:0]         byte_idx;
    logic [4:0]         last_idx;
    logic [2:0]         bit_idx;
    logic [7:0]         sh;
    logic [7:0]         shifted;
    logic [7:0]         byte_in;
    logic [7:0]         next_byte;
    logic [7:0]         rd;
    logic [1:0]         rd_k;
    logic               reading;
    logic               dio_oe;
    logic               dio_out;
    panel_t             snap;

    // Byte number idx of burst b, data bytes alternate digit and LED
    function automatic logic [7:0] tx_byte(input logic [1:0] b, input logic [4:0] idx,
                                           input panel_t p);
        logic [3:0] k;
        k = 4'(idx - 5'd1);
        case (b)
            2'd0:    return tm_cmd_write_auto;
            2'd1:    return (idx == 5'd0) ? tm_cmd_addr0
                          : (k[0] ? {7'b0, p.led[k[3:1]]} : p.digit[k[3:1]]);
            2'd2:    return tm_cmd_display_on;
            default: return tm_cmd_read_keys;
        endcase
    endfunction

    assign sio_data = dio_oe ? dio_out : 1'bz;

    // ------------------------------
    // Half period tick of the serial clock
    assign tick = (div_cnt == w_div'(half_div - 1));

    always_ff @(posedge clk)
    begin
        if (!rst_n || tick)
            div_cnt <= '0;
        else
            div_cnt <= div_cnt + 1'b1;
    end

    assign reading   = (burst == 2'd3) && (byte_idx != 5'd0);
    assign last_idx  = (burst == 2'd1) ? 5'd16 : ((burst == 2'd3) ? 5'd4 : 5'd0);
    assign byte_in   = {sio_data, sh[7:1]};
    assign shifted   = reading ? byte_in : {1'b0, sh[7:1]};
    assign next_byte = tx_byte(burst, byte_idx + 5'd1, snap);
    assign rd_k      = 2'(byte_idx - 5'd1);

    // ------------------------------
    // Burst sequencer
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state    <= ST_GAP;
            burst    <= '0;
            byte_idx <= '0;
            bit_idx  <= '0;
            sio_stb  <= 1'b1;
            sio_clk  <= 1'b1;
            dio_oe   <= 1'b1;
            dio_out  <= 1'b1;
            keys     <= '0;
        end
        else if (tick)
        begin
            unique case (state)
                ST_GAP:
                begin
                    // Panel contents are frozen for the whole loop
                    if (burst == 2'd0)
                        snap <= panel;
                    sh      <= tx_byte(burst, 5'd0, snap);
                    sio_stb <= 1'b0;
                    state   <= ST_START;
                end
                ST_START:
                begin
                    sio_clk <= 1'b0;
                    dio_out <= sh[0];
                    state   <= ST_LOW;
                end
                ST_LOW:
                begin
                    sio_clk <= 1'b1;
                    state   <= ST_HIGH;
                end
                ST_HIGH:
                begin
                    sh <= shifted;
                    if (bit_idx != 3'd7)
                    begin
                        bit_idx <= bit_idx + 3'd1;
                        sio_clk <= 1'b0;
                        if (!reading)
                            dio_out <= shifted[0];
                        state <= ST_LOW;
                    end
                    else
                    begin
                        bit_idx <= '0;
                        // Keys 2k and 2k+1 sit in bits 0 and 4 of read byte k
                        if (reading)
                        begin
                            rd[{rd_k, 1'b0}] <= byte_in[0];
                            rd[{rd_k, 1'b1}] <= byte_in[4];
                        end
                        if (reading && byte_idx == 5'd4)
                            keys <= {byte_in[4], byte_in[0], rd[5:0]};
                        if (byte_idx == last_idx)
                            state <= ST_STOP;
                        else
                        begin
                            byte_idx <= byte_idx + 5'd1;
                            sh       <= next_byte;
                            sio_clk  <= 1'b0;
                            if (burst == 2'd3)
                                dio_oe <= 1'b0;
                            else
                                dio_out <= next_byte[0];
                            state <= ST_LOW;
                        end
                    end
                end
                default:
                begin
                    sio_stb  <= 1'b1;
                    dio_oe   <= 1'b1;
                    dio_out  <= 1'b1;
                    byte_idx <= '0;
                    burst    <= burst + 2'd1;
                    state    <= ST_GAP;
                end
            endcase
        end
    end

endmodule

// File: src/i2s_audio_out.sv
/*
 * I2S audio transmitter, 16-bit samples on both channels
 * Takes one sample per frame and repeats the last one when none waits
 */

module i2s_audio_out
    import board_pkg::*;
#(
    parameter int i2s_clk_div = 8
)
(
    input  logic          clk,
    input  logic          rst_n,
    input  logic          in_valid,
    input  audio_sample_t in_sample,
    output logic          in_ready,
    output logic          mclk,
    output logic          bclk,
    output logic          lrclk,
    output logic          sdata
);

    localparam int half_div = i2s_clk_div / 2;
    localparam int w_div    = $clog2(i2s_clk_div);

    logic [w_div - 1:0] div_cnt;
    logic [4:0]         bit_cnt;
    logic [15:0]        shift;
    audio_sample_t      last_sample;
    logic               rise;
    logic               fall;
    logic               half_start;
    logic               frame_start;

    assign rise        = (div_cnt == w_div'(half_div - 1));
    assign fall        = (div_cnt == w_div'(i2s_clk_div - 1));
    assign half_start  = fall && (bit_cnt[3:0] == 4'hf);
    assign frame_start = half_start && bit_cnt[4];

    // One-clk ready window at each frame start
    assign in_ready = frame_start;

    // ------------------------------
    // Master clock, bit clock and frame position
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            mclk    <= 1'b0;
            div_cnt <= '0;
            bit_cnt <= '0;
            bclk    <= 1'b0;
        end
        else
        begin
            mclk <= ~mclk;
            if (fall)
            begin
                div_cnt <= '0;
                bit_cnt <= bit_cnt + 5'd1;
                bclk    <= 1'b0;
            end
            else
            begin
                div_cnt <= div_cnt + 1'b1;
                if (rise)
                    bclk <= 1'b1;
            end
        end
    end

    assign lrclk = bit_cnt[4];

    // ------------------------------
    // Serializer, updated on the bclk falling edge.
    // Slot 0 of each half still carries the LSB of the word before it
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            shift       <= '0;
            last_sample <= '0;
            sdata       <= 1'b0;
        end
        else if (fall)
        begin
            sdata <= shift[15];
            if (frame_start && in_valid)
            begin
                shift       <= in_sample;
                last_sample <= in_sample;
            end
            else if (half_start)
                shift <= last_sample;
            else
                shift <= {shift[14:0], 1'b0};
        end
    end

endmodule

// File: src/i2s_mic_receiver.sv
/*
 * I2S microphone receiver, bus master for an INMP441 type part
 * Drives sck and ws and captures the 24-bit left channel word
 */

module i2s_mic_receiver
    import board_pkg::*;
#(
    parameter int i2s_clk_div = 8
)
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        sd,
    output logic        sck,
    output logic        ws,
    output mic_sample_t sample,
    output logic        sample_valid
);

    localparam int half_div = i2s_clk_div / 2;
    localparam int w_div    = $clog2(i2s_clk_div);

    logic [w_div - 1:0] div_cnt;
    logic [5:0]         bit_cnt;
    logic [22:0]        shift;
    logic               rise;
    logic               fall;

    assign rise = (div_cnt == w_div'(half_div - 1));
    assign fall = (div_cnt == w_div'(i2s_clk_div - 1));

    // ------------------------------
    // Bit clock and position in the 64-bit frame
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            div_cnt <= '0;
            bit_cnt <= '0;
            sck     <= 1'b0;
        end
        else if (fall)
        begin
            div_cnt <= '0;
            bit_cnt <= bit_cnt + 6'd1;
            sck     <= 1'b0;
        end
        else
        begin
            div_cnt <= div_cnt + 1'b1;
            if (rise)
                sck <= 1'b1;
        end
    end

    // Low for the left half, high for the right half
    assign ws = bit_cnt[5];

    // ------------------------------
    // Slot 0 is the I2S delay bit, data sits in slots 1 to 24
    always_ff @(posedge clk)
    begin
        if (rise && bit_cnt >= 6'd1 && bit_cnt <= 6'd23)
            shift <= {shift[21:0], sd};
        if (rise && bit_cnt == 6'd24)
            sample <= {shift, sd};
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            sample_valid <= 1'b0;
        else
            sample_valid <= rise && (bit_cnt == 6'd24);
    end

endmodule

// File: src/board_pkg.sv
/*
 * Board package with sample, gain and panel types, TM1638 commands
 * and the hex to seven-segment decoder
 */

package board_pkg;

    typedef logic signed [23:0] mic_sample_t;
    typedef logic signed [15:0] audio_sample_t;
    typedef logic        [2:0]  gain_t;
    typedef logic        [7:0]  tm_keys_t;

    // Segment bytes are hgfedcba, digit 0 is the rightmost
    typedef struct packed {
        logic [7:0][7:0] digit;
        logic      [7:0] led;
    } panel_t;

    // ------------------------------
    // TM1638 command bytes
    localparam logic [7:0] tm_cmd_write_auto = 8'h40;
    localparam logic [7:0] tm_cmd_read_keys  = 8'h42;
    localparam logic [7:0] tm_cmd_addr0      = 8'hc0;
    localparam logic [7:0] tm_cmd_display_on = 8'h8f;

    function automatic logic [7:0] seg_hex(input logic [3:0] value);
        case (value)
            4'h0:    return 8'h3f;
            4'h1:    return 8'h06;
            4'h2:    return 8'h5b;
            4'h3:    return 8'h4f;
            4'h4:    return 8'h66;
            4'h5:    return 8'h6d;
            4'h6:    return 8'h7d;
            4'h7:    return 8'h07;
            4'h8:    return 8'h7f;
            4'h9:    return 8'h6f;
            4'ha:    return 8'h77;
            4'hb:    return 8'h7c;
            4'hc:    return 8'h39;
            4'hd:    return 8'h5e;
            4'he:    return 8'h79;
            default: return 8'h71;
        endcase
    endfunction

endpackage
